// ==== source/mci_pkg.sv ====
// MCI watchdog and error aggregator package
// Register map, bus word types and the two views of a register write word

package mci_pkg;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam reg_addr_t ADDR_WDT_CTRL       = 4'h0;
  localparam reg_addr_t ADDR_WDT_T1_PERIOD  = 4'h1;
  localparam reg_addr_t ADDR_WDT_T2_PERIOD  = 4'h2;
  localparam reg_addr_t ADDR_WDT_RESTART    = 4'h3;
  localparam reg_addr_t ADDR_WDT_STATUS     = 4'h4;
  localparam reg_addr_t ADDR_ERR_FATAL      = 4'h5;
  localparam reg_addr_t ADDR_ERR_NON_FATAL  = 4'h6;
  localparam reg_addr_t ADDR_MASK_FATAL     = 4'h7;
  localparam reg_addr_t ADDR_MASK_NON_FATAL = 4'h8;

  //////////////////////////////
  // Watchdog word layout
  //////////////////////////////

  // Same positions in CTRL (enable), RESTART (pet) and STATUS (timeout, W1C)
  typedef struct packed {
    logic [29:0] rsvd;
    logic        t2;
    logic        t1;
  } wdt_bits_t;

  // A write word is either a raw value or a set of per-timer bits
  typedef union packed {
    reg_data_t raw;
    wdt_bits_t bits;
  } wdt_wdata_u;

endpackage

// ==== source/mci_if.sv ====
// MCI internal interfaces
// wdt_ctrl_if carries watchdog configuration, pulses and timeout flags
// err_ctrl_if carries error masks, clear pulses and sticky status

`timescale 1ns/1ps

interface wdt_ctrl_if #(
  parameter int CNT_W = 32
);

  logic             t1_en;
  logic             t2_en;
  logic [CNT_W-1:0] t1_period;
  logic [CNT_W-1:0] t2_period;
  logic             t1_restart;
  logic             t2_restart;
  logic             t1_service;
  logic             t2_service;
  logic             t1_timeout;
  logic             t2_timeout;

  modport csr (
    output t1_en, t2_en, t1_period, t2_period,
    output t1_restart, t2_restart, t1_service, t2_service,
    input  t1_timeout, t2_timeout
  );

  modport wdt (
    input  t1_en, t2_en, t1_period, t2_period,
    input  t1_restart, t2_restart, t1_service, t2_service,
    output t1_timeout, t2_timeout
  );

endinterface

interface err_ctrl_if #(
  parameter int NUM_FATAL     = 4,
  parameter int NUM_NON_FATAL = 4
);

  // The top fatal bit is the watchdog source
  logic [NUM_FATAL:0]       fatal_mask;
  logic [NUM_FATAL:0]       fatal_clr;
  logic [NUM_FATAL:0]       fatal_status;
  logic [NUM_NON_FATAL-1:0] non_fatal_mask;
  logic [NUM_NON_FATAL-1:0] non_fatal_clr;
  logic [NUM_NON_FATAL-1:0] non_fatal_status;

  modport csr (
    output fatal_mask, non_fatal_mask, fatal_clr, non_fatal_clr,
    input  fatal_status, non_fatal_status
  );

  modport agg (
    input  fatal_mask, non_fatal_mask, fatal_clr, non_fatal_clr,
    output fatal_status, non_fatal_status
  );

endinterface

// ==== source/mci_csr.sv ====
// MCI register block
// Decodes register writes into watchdog and error configuration,
// turns RESTART, STATUS and error writes into one-cycle pulses,
// and returns configuration and status on a combinational read port

`timescale 1ns/1ps

module mci_csr
  import mci_pkg::*;
#(
  parameter int CNT_W         = 32,
  parameter int NUM_FATAL     = 4,
  parameter int NUM_NON_FATAL = 4
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      reg_we_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  wdt_ctrl_if.csr   wdt,
  err_ctrl_if.csr   err
);

  wdt_wdata_u wdata_u;
  wdt_wdata_u rdata_u;
  logic       wr_ctrl;
  logic       wr_t1_period;
  logic       wr_t2_period;
  logic       wr_restart;
  logic       wr_status;
  logic       wr_err_fatal;
  logic       wr_err_non_fatal;
  logic       wr_mask_fatal;
  logic       wr_mask_non_fatal;

  assign wdata_u = reg_wdata_i;

  assign wr_ctrl           = reg_we_i && (reg_addr_i == ADDR_WDT_CTRL);
  assign wr_t1_period      = reg_we_i && (reg_addr_i == ADDR_WDT_T1_PERIOD);
  assign wr_t2_period      = reg_we_i && (reg_addr_i == ADDR_WDT_T2_PERIOD);
  assign wr_restart        = reg_we_i && (reg_addr_i == ADDR_WDT_RESTART);
  assign wr_status         = reg_we_i && (reg_addr_i == ADDR_WDT_STATUS);
  assign wr_err_fatal      = reg_we_i && (reg_addr_i == ADDR_ERR_FATAL);
  assign wr_err_non_fatal  = reg_we_i && (reg_addr_i == ADDR_ERR_NON_FATAL);
  assign wr_mask_fatal     = reg_we_i && (reg_addr_i == ADDR_MASK_FATAL);
  assign wr_mask_non_fatal = reg_we_i && (reg_addr_i == ADDR_MASK_NON_FATAL);

  //////////////////////////////
  // Configuration and pulses
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wdt.t1_en          <= 1'b0;
      wdt.t2_en          <= 1'b0;
      wdt.t1_period      <= '0;
      wdt.t2_period      <= '0;
      wdt.t1_restart     <= 1'b0;
      wdt.t2_restart     <= 1'b0;
      wdt.t1_service     <= 1'b0;
      wdt.t2_service     <= 1'b0;
      err.fatal_mask     <= '0;
      err.non_fatal_mask <= '0;
      err.fatal_clr      <= '0;
      err.non_fatal_clr  <= '0;
    end else begin
      if (wr_ctrl) begin
        wdt.t1_en <= wdata_u.bits.t1;
        wdt.t2_en <= wdata_u.bits.t2;
      end
      if (wr_t1_period) begin
        wdt.t1_period <= wdata_u.raw[CNT_W-1:0];
      end
      if (wr_t2_period) begin
        wdt.t2_period <= wdata_u.raw[CNT_W-1:0];
      end
      if (wr_mask_fatal) begin
        err.fatal_mask <= wdata_u.raw[NUM_FATAL:0];
      end
      if (wr_mask_non_fatal) begin
        err.non_fatal_mask <= wdata_u.raw[NUM_NON_FATAL-1:0];
      end
      // Pulses are high for the single cycle after the write edge
      wdt.t1_restart    <= wr_restart && wdata_u.bits.t1;
      wdt.t2_restart    <= wr_restart && wdata_u.bits.t2;
      wdt.t1_service    <= wr_status && wdata_u.bits.t1;
      wdt.t2_service    <= wr_status && wdata_u.bits.t2;
      err.fatal_clr     <= wr_err_fatal ? wdata_u.raw[NUM_FATAL:0] : '0;
      err.non_fatal_clr <= wr_err_non_fatal ? wdata_u.raw[NUM_NON_FATAL-1:0] : '0;
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  // RESTART has no storage and reads back as zero
  always_comb begin
    rdata_u = '0;
    case (reg_addr_i)
      ADDR_WDT_CTRL: begin
        rdata_u.bits.t1 = wdt.t1_en;
        rdata_u.bits.t2 = wdt.t2_en;
      end
      ADDR_WDT_STATUS: begin
        rdata_u.bits.t1 = wdt.t1_timeout;
        rdata_u.bits.t2 = wdt.t2_timeout;
      end
      ADDR_WDT_T1_PERIOD:  rdata_u.raw = reg_data_t'(wdt.t1_period);
      ADDR_WDT_T2_PERIOD:  rdata_u.raw = reg_data_t'(wdt.t2_period);
      ADDR_ERR_FATAL:      rdata_u.raw = reg_data_t'(err.fatal_status);
      ADDR_ERR_NON_FATAL:  rdata_u.raw = reg_data_t'(err.non_fatal_status);
      ADDR_MASK_FATAL:     rdata_u.raw = reg_data_t'(err.fatal_mask);
      ADDR_MASK_NON_FATAL: rdata_u.raw = reg_data_t'(err.non_fatal_mask);
      default:             rdata_u.raw = '0;
    endcase
  end

  assign reg_rdata_o = rdata_u.raw;

endmodule

// ==== source/mci_wdt.sv ====
// MCI two-stage watchdog timer
// Timer 1 and timer 2 count up to their periods and raise sticky timeout flags.
// With t2_en clear timer 2 runs only after timer 1 has timed out (cascade),
// with t2_en set both timers run on their own (independent)

`timescale 1ns/1ps

module mci_wdt #(
  parameter int CNT_W = 32
) (
  input  logic    clk_i,
  input  logic    rst_i,
  wdt_ctrl_if.wdt ctrl
);

  // Index 0 is timer 1, index 1 is timer 2
  logic [1:0][CNT_W-1:0] cnt_q;
  logic [1:0][CNT_W-1:0] period;
  logic [1:0]            timeout_q;
  logic [1:0]            restart;
  logic [1:0]            service;
  logic [1:0]            run;
  logic [1:0]            zero;
  logic                  cascade;

  assign cascade = !ctrl.t2_en;
  assign period  = {ctrl.t2_period, ctrl.t1_period};
  assign restart = {ctrl.t2_restart, ctrl.t1_restart};
  assign service = {ctrl.t2_service, ctrl.t1_service};

  // A timer stops counting once its timeout flag is set
  assign run[0] = ctrl.t1_en && !timeout_q[0];
  assign run[1] = (cascade ? timeout_q[0] : 1'b1) && !timeout_q[1];

  // In cascade mode timer 2 is held at zero until timer 1 expires
  assign zero[0] = restart[0] || service[0];
  assign zero[1] = restart[1] || service[1] || (cascade && !timeout_q[0]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q     <= '0;
      timeout_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (zero[i]) begin
          cnt_q[i] <= '0;
        end else if (run[i]) begin
          // Count holds at the period while the flag sets
          if (cnt_q[i] == period[i]) begin
            timeout_q[i] <= 1'b1;
          end else begin
            cnt_q[i] <= cnt_q[i] + CNT_W'(1);
          end
        end
        if (service[i]) begin
          timeout_q[i] <= 1'b0;
        end
      end
    end
  end

  assign ctrl.t1_timeout = timeout_q[0];
  assign ctrl.t2_timeout = timeout_q[1];

endmodule

// ==== source/mci_error_agg.sv ====
// MCI hardware error aggregator
// Keeps sticky fatal and non-fatal error status with write-one-to-clear,
// applies the masks and registers one aggregated flag per class

`timescale 1ns/1ps

module mci_error_agg #(
  parameter int NUM_FATAL     = 4,
  parameter int NUM_NON_FATAL = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [NUM_FATAL-1:0]     err_fatal_i,
  input  logic [NUM_NON_FATAL-1:0] err_non_fatal_i,
  input  logic                     wdt_fatal_i,
  output logic                     all_error_fatal_o,
  output logic                     all_error_non_fatal_o,
  err_ctrl_if.agg                  ctrl
);

  logic [NUM_FATAL:0]       fatal_src;
  logic [NUM_FATAL:0]       fatal_q;
  logic [NUM_NON_FATAL-1:0] non_fatal_q;

  // Watchdog expiry is the extra fatal source in the top bit
  assign fatal_src = {wdt_fatal_i, err_fatal_i};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fatal_q               <= '0;
      non_fatal_q           <= '0;
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      // A source still high in the clear cycle keeps its bit set
      fatal_q     <= (fatal_q & ~ctrl.fatal_clr) | fatal_src;
      non_fatal_q <= (non_fatal_q & ~ctrl.non_fatal_clr) | err_non_fatal_i;
      // A set mask bit hides its status bit from the aggregate
      all_error_fatal_o     <= |(fatal_q & ~ctrl.fatal_mask);
      all_error_non_fatal_o <= |(non_fatal_q & ~ctrl.non_fatal_mask);
    end
  end

  assign ctrl.fatal_status     = fatal_q;
  assign ctrl.non_fatal_status = non_fatal_q;

endmodule

// ==== source/mci_top.sv ====
// MCI watchdog and error aggregation top level
// Connects the register block, the two-stage watchdog and the error
// aggregator. Timer 1 expiry is the interrupt and timer 2 expiry is fatal

`timescale 1ns/1ps

module mci_top
  import mci_pkg::*;
#(
  parameter int CNT_W         = 32,
  parameter int NUM_FATAL     = 4,
  parameter int NUM_NON_FATAL = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     reg_we_i,
  input  reg_addr_t                reg_addr_i,
  input  reg_data_t                reg_wdata_i,
  output reg_data_t                reg_rdata_o,
  input  logic [NUM_FATAL-1:0]     err_fatal_i,
  input  logic [NUM_NON_FATAL-1:0] err_non_fatal_i,
  output logic                     wdt_irq_o,
  output logic                     all_error_fatal_o,
  output logic                     all_error_non_fatal_o
);

  wdt_ctrl_if #(.CNT_W(CNT_W)) wdt_if ();
  err_ctrl_if #(.NUM_FATAL(NUM_FATAL), .NUM_NON_FATAL(NUM_NON_FATAL)) err_if ();

  mci_csr #(
    .CNT_W         (CNT_W),
    .NUM_FATAL     (NUM_FATAL),
    .NUM_NON_FATAL (NUM_NON_FATAL)
  ) u_csr (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .wdt         (wdt_if.csr),
    .err         (err_if.csr)
  );

  mci_wdt #(
    .CNT_W (CNT_W)
  ) u_wdt (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ctrl  (wdt_if.wdt)
  );

  mci_error_agg #(
    .NUM_FATAL     (NUM_FATAL),
    .NUM_NON_FATAL (NUM_NON_FATAL)
  ) u_error_agg (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .err_fatal_i           (err_fatal_i),
    .err_non_fatal_i       (err_non_fatal_i),
    .wdt_fatal_i           (wdt_if.t2_timeout),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o),
    .ctrl                  (err_if.agg)
  );

  assign wdt_irq_o = wdt_if.t1_timeout;

endmodule

// ==== verif/mci_wdt_sva.sv ====
// MCI watchdog assertions
// Bound into mci_wdt; checks count zeroing, sticky timeout flags
// and the cascade hold of timer 2

`timescale 1ns/1ps

module mci_wdt_sva #(
  parameter int CNT_W = 32
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic [1:0][CNT_W-1:0] cnt_i,
  input logic [1:0]            timeout_i,
  input logic [1:0]            restart_i,
  input logic [1:0]            service_i,
  input logic                  cascade_i
);

  // A restart or service pulse zeroes the count at the next edge
  t1_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (restart_i[0] || service_i[0]) |=> cnt_i[0] == '0)
    else $error("Timer 1 count not zero after restart or service");

  t2_zero_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (restart_i[1] || service_i[1]) |=> cnt_i[1] == '0)
    else $error("Timer 2 count not zero after restart or service");

  t1_sticky_a: assert property (@(posedge clk_i) disable iff (rst_i)
    timeout_i[0] && !service_i[0] |=> timeout_i[0])
    else $error("Timer 1 timeout flag dropped without service");

  t2_sticky_a: assert property (@(posedge clk_i) disable iff (rst_i)
    timeout_i[1] && !service_i[1] |=> timeout_i[1])
    else $error("Timer 2 timeout flag dropped without service");

  // Timer 2 waits for timer 1 expiry in cascade mode
  cascade_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cascade_i && !timeout_i[0] |=> cnt_i[1] == '0)
    else $error("Timer 2 counted in cascade mode before timer 1 expired");

endmodule

bind mci_wdt mci_wdt_sva #(.CNT_W(CNT_W)) u_wdt_sva (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .cnt_i     (cnt_q),
  .timeout_i (timeout_q),
  .restart_i (restart),
  .service_i (service),
  .cascade_i (cascade)
);

// ==== verif/mci_tb.sv ====
// MCI watchdog and error aggregator testbench
// Runs reset, cascade, restart and independent watchdog tests, then a
// random error phase checked against a cycle model of the aggregator

`timescale 1ns/1ps

module mci_tb
  import mci_pkg::*;
();

  localparam int CNT_W  = 32;
  localparam int NF     = 4;
  localparam int NNF    = 4;
  localparam int P1     = 20;
  localparam int P2     = 12;
  localparam int N_PETS = 8;
  localparam int N_RAND = 200;
  // Watchdog phases wait about 9 timer 1 and 2 timer 2 periods
  localparam int MAX_CYCLES = 9 * P1 + 2 * P2 + N_RAND + 200;

  logic           clk_i;
  logic           rst_i;
  logic           reg_we_i;
  reg_addr_t      reg_addr_i;
  reg_data_t      reg_wdata_i;
  reg_data_t      reg_rdata_o;
  logic [NF-1:0]  err_fatal_i;
  logic [NNF-1:0] err_non_fatal_i;
  logic           wdt_irq_o;
  logic           all_error_fatal_o;
  logic           all_error_non_fatal_o;

  int             data_errs;
  int             bit_errs;
  int             time_errs;
  int             cycles;
  logic           model_on;
  logic [NF:0]    m_fatal;
  logic [NF:0]    m_mask_f;
  logic [NF:0]    m_clr_f;
  logic [NNF-1:0] m_nf;
  logic [NNF-1:0] m_mask_nf;
  logic [NNF-1:0] m_clr_nf;
  logic           exp_f;
  logic           exp_nf;

  mci_top #(
    .CNT_W         (CNT_W),
    .NUM_FATAL     (NF),
    .NUM_NON_FATAL (NNF)
  ) i_dut (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .reg_we_i              (reg_we_i),
    .reg_addr_i            (reg_addr_i),
    .reg_wdata_i           (reg_wdata_i),
    .reg_rdata_o           (reg_rdata_o),
    .err_fatal_i           (err_fatal_i),
    .err_non_fatal_i       (err_non_fatal_i),
    .wdt_irq_o             (wdt_irq_o),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  //////////////////////////////
  // Checks and bus tasks
  //////////////////////////////

  // Any status bit whose mask bit is clear raises the aggregate
  function automatic logic exp_agg(input logic [7:0] status, input logic [7:0] mask);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (status[i] && !mask[i]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
      data_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] expected %b actual %b at %0t", name, exp, act, $time);
      bit_errs++;
    end
  endtask

  // The bus parks on STATUS so timer 2 expiry is visible on the read port
  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk_i);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i   <= 1'b0;
    reg_addr_i <= ADDR_WDT_STATUS;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(posedge clk_i);
    reg_addr_i <= addr;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr, input reg_data_t exp);
    reg_data_t act;
    reg_read(addr, act);
    check_data(name, exp, act);
  endtask

  function automatic logic probe(input int which);
    case (which)
      0:       return wdt_irq_o;
      1:       return reg_rdata_o[1];
      default: return all_error_fatal_o;
    endcase
  endfunction

  // Counts falling edges until the chosen level rises and checks the window
  task automatic wait_level(input string name, input int which, input int lo, input int hi);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!probe(which) && n <= hi) begin
      @(negedge clk_i);
      n++;
    end
    if (n < lo || n > hi) begin
      $display("Timing check %s failed: level seen after %0d cycles, expected %0d to %0d",
               name, n, lo, hi);
      time_errs++;
    end
  endtask

  //////////////////////////////
  // Aggregator model
  //////////////////////////////

  // Status sets on the source edge and the outputs follow one edge later
  always @(posedge clk_i) begin
    if (rst_i || !model_on) begin
      m_fatal   = '0;
      m_mask_f  = '0;
      m_clr_f   = '0;
      m_nf      = '0;
      m_mask_nf = '0;
      m_clr_nf  = '0;
      exp_f     = 1'b0;
      exp_nf    = 1'b0;
    end else begin
      exp_f   = exp_agg(8'(m_fatal), 8'(m_mask_f));
      exp_nf  = exp_agg(8'(m_nf), 8'(m_mask_nf));
      m_fatal = (m_fatal & ~m_clr_f) | {1'b0, err_fatal_i};
      m_nf    = (m_nf & ~m_clr_nf) | err_non_fatal_i;
      m_clr_f  = (reg_we_i && reg_addr_i == ADDR_ERR_FATAL) ? reg_wdata_i[NF:0] : '0;
      m_clr_nf = (reg_we_i && reg_addr_i == ADDR_ERR_NON_FATAL) ? reg_wdata_i[NNF-1:0] : '0;
      if (reg_we_i && reg_addr_i == ADDR_MASK_FATAL) begin
        m_mask_f = reg_wdata_i[NF:0];
      end
      if (reg_we_i && reg_addr_i == ADDR_MASK_NON_FATAL) begin
        m_mask_nf = reg_wdata_i[NNF-1:0];
      end
    end
  end

  always @(negedge clk_i) begin
    if (model_on) begin
      check_bit("agg_fatal", exp_f, all_error_fatal_o);
      check_bit("agg_non_fatal", exp_nf, all_error_non_fatal_o);
      if (reg_addr_i == ADDR_ERR_FATAL) begin
        check_data("err_fatal_read", reg_data_t'(m_fatal), reg_rdata_o);
      end
      if (reg_addr_i == ADDR_ERR_NON_FATAL) begin
        check_data("err_non_fatal_read", reg_data_t'(m_nf), reg_rdata_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Run stopped: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int unsigned op;
    void'($urandom(32'hdf04));
    data_errs       = 0;
    bit_errs        = 0;
    time_errs       = 0;
    cycles          = 0;
    model_on        = 1'b0;
    rst_i           = 1'b1;
    reg_we_i        = 1'b0;
    reg_addr_i      = ADDR_WDT_STATUS;
    reg_wdata_i     = '0;
    err_fatal_i     = '0;
    err_non_fatal_i = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // Reset values
    @(negedge clk_i);
    check_bit("reset_irq", 1'b0, wdt_irq_o);
    check_bit("reset_fatal", 1'b0, all_error_fatal_o);
    check_bit("reset_non_fatal", 1'b0, all_error_non_fatal_o);
    expect_reg("reset_status", ADDR_WDT_STATUS, '0);
    expect_reg("reset_err_fatal", ADDR_ERR_FATAL, '0);
    expect_reg("reset_err_non_fatal", ADDR_ERR_NON_FATAL, '0);

    // Cascade mode with timer 1 enabled only
    reg_write(ADDR_WDT_T1_PERIOD, P1);
    reg_write(ADDR_WDT_T2_PERIOD, P2);
    expect_reg("t1_period", ADDR_WDT_T1_PERIOD, P1);
    reg_write(ADDR_WDT_CTRL, 32'h1);
    wait_level("t1_cascade", 0, P1, P1 + 2);
    wait_level("t2_cascade", 1, P2, P2 + 2);
    wait_level("fatal_from_wdt", 2, 0, 3);
    check_bit("non_fatal_quiet", 1'b0, all_error_non_fatal_o);
    reg_write(ADDR_WDT_CTRL, 32'h0);
    reg_write(ADDR_WDT_STATUS, 32'h3);
    reg_write(ADDR_ERR_FATAL, 32'h1 << NF);

    // Regular pets keep timer 1 from expiring
    reg_write(ADDR_WDT_CTRL, 32'h1);
    repeat (N_PETS) begin
      repeat (P1 / 2 - 1) @(negedge clk_i);
      check_bit("irq_while_petting", 1'b0, wdt_irq_o);
      reg_write(ADDR_WDT_RESTART, 32'h1);
    end
    wait_level("t1_after_pets", 0, P1, P1 + 2);

    // Independent mode where timer 2 is the shorter one
    reg_write(ADDR_WDT_CTRL, 32'h0);
    reg_write(ADDR_WDT_STATUS, 32'h3);
    reg_write(ADDR_WDT_CTRL, 32'h3);
    wait_level("t2_independent", 1, P2, P2 + 2);
    check_bit("t1_still_running", 1'b0, wdt_irq_o);
    wait_level("t1_independent", 0, P1 - P2 - 2, P1 - P2);
    reg_write(ADDR_WDT_STATUS, 32'h1);
    @(negedge clk_i);
    @(negedge clk_i);
    check_bit("irq_serviced", 1'b0, wdt_irq_o);
    wait_level("t1_after_service", 0, P1, P1 + 2);

    // Quiet the watchdog and clear all error state before the random phase
    reg_write(ADDR_WDT_CTRL, 32'h0);
    reg_write(ADDR_WDT_STATUS, 32'h3);
    reg_write(ADDR_ERR_FATAL, '1);
    reg_write(ADDR_ERR_NON_FATAL, '1);
    reg_write(ADDR_MASK_FATAL, '0);
    expect_reg("clean_err_fatal", ADDR_ERR_FATAL, '0);
    expect_reg("clean_err_non_fatal", ADDR_ERR_NON_FATAL, '0);
    @(posedge clk_i);
    model_on <= 1'b1;

    repeat (N_RAND) begin
      @(posedge clk_i);
      err_fatal_i     <= ($urandom_range(5) == 0) ? NF'($urandom) : '0;
      err_non_fatal_i <= ($urandom_range(5) == 0) ? NNF'($urandom) : '0;
      op = $urandom_range(9);
      reg_we_i    <= (op < 4);
      reg_wdata_i <= $urandom;
      case (op)
        0:       reg_addr_i <= ADDR_MASK_FATAL;
        1:       reg_addr_i <= ADDR_MASK_NON_FATAL;
        2:       reg_addr_i <= ADDR_ERR_FATAL;
        3:       reg_addr_i <= ADDR_ERR_NON_FATAL;
        default: reg_addr_i <= op[0] ? ADDR_ERR_FATAL : ADDR_ERR_NON_FATAL;
      endcase
    end
    @(posedge clk_i);
    err_fatal_i     <= '0;
    err_non_fatal_i <= '0;
    reg_we_i        <= 1'b0;

    // A masked error is recorded but never reaches the output
    reg_write(ADDR_ERR_FATAL, '1);
    reg_write(ADDR_ERR_NON_FATAL, '1);
    reg_write(ADDR_MASK_FATAL, 32'h1);
    @(posedge clk_i);
    err_fatal_i <= 4'h1;
    @(posedge clk_i);
    err_fatal_i <= '0;
    repeat (4) @(negedge clk_i);
    check_bit("masked_fatal", 1'b0, all_error_fatal_o);
    expect_reg("masked_status", ADDR_ERR_FATAL, 32'h1);
    expect_reg("final_err_non_fatal", ADDR_ERR_NON_FATAL, reg_data_t'(m_nf));

    $display("Error counts: data %0d, bit %0d, timing %0d", data_errs, bit_errs, time_errs);
    if (data_errs + bit_errs + time_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== mci_wdt_err.f ====
source/mci_pkg.sv
source/mci_if.sv
source/mci_csr.sv
source/mci_wdt.sv
source/mci_error_agg.sv
source/mci_top.sv
verif/mci_wdt_sva.sv
verif/mci_tb.sv

// ==== Bender.yml ====
package:
  name: mci_wdt_err

sources:
  - source/mci_pkg.sv
  - source/mci_if.sv
  - source/mci_csr.sv
  - source/mci_wdt.sv
  - source/mci_error_agg.sv
  - source/mci_top.sv
  - target: test
    files:
      - verif/mci_wdt_sva.sv
      - verif/mci_tb.sv
